// ==== common/vgaPkg.sv ====
package vgaPkg;

  // screen counter value, wide enough for an 800 x 525 frame
  typedef logic [9:0] screenCoord_t;

  // brush coordinate
  // bit 7 set means the stroke lies off the canvas
  typedef logic [7:0] canvasCoord_t;

  // canvas address, row in [13:7] and column in [6:0]
  typedef logic [13:0] canvasAddr_t;

  // canvas edge in pixels
  localparam int CANVAS_SIZE = 128;

  // one word per canvas pixel
  localparam int CANVAS_DEPTH = CANVAS_SIZE * CANVAS_SIZE;

endpackage

// ==== common/colorPkg.sv ====
package colorPkg;

  // palette index stored per canvas pixel
  typedef logic [2:0] colorCode_t;

  // 4 bits per channel, red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [11:0] rgb_t;

  // named codes
  // erase is what a clear writes, outside fills the area beyond the canvas
  localparam colorCode_t erase   = 3'd0;
  localparam colorCode_t red     = 3'd1;
  localparam colorCode_t green   = 3'd2;
  localparam colorCode_t blue    = 3'd3;
  localparam colorCode_t yellow  = 3'd4;
  localparam colorCode_t purple  = 3'd5;
  localparam colorCode_t white   = 3'd6;
  localparam colorCode_t outside = 3'd7;

  // blanking output
  localparam rgb_t rgbBlack = 12'h000;

  // palette, indexed by color code
  // erase is a dark gray so a cleared canvas differs from blanking
  localparam rgb_t paletteTable [8] = '{
    12'h222,
    12'hF00,
    12'h0F0,
    12'h00F,
    12'hFF0,
    12'hA0F,
    12'hFFF,
    12'h458
  };

endpackage

// ==== source/vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming #(
  parameter int hActive = 640,
  parameter int hFront  = 16,
  parameter int hSync   = 96,
  parameter int hBack   = 48,
  parameter int vActive = 480,
  parameter int vFront  = 10,
  parameter int vSync   = 2,
  parameter int vBack   = 33
) (
  input  logic                 clk,
  input  logic                 rst,
  output vgaPkg::screenCoord_t hPos,
  output vgaPkg::screenCoord_t vPos,
  output logic                 active,
  output logic                 hsyncRaw,
  output logic                 vsyncRaw
);

  import vgaPkg::*;

  // line and frame totals
  localparam int hTotal = hActive + hFront + hSync + hBack;
  localparam int vTotal = vActive + vFront + vSync + vBack;

  // last count before wrap
  localparam screenCoord_t hLast = screenCoord_t'(hTotal - 1);
  localparam screenCoord_t vLast = screenCoord_t'(vTotal - 1);

  // window edges, sync window follows active plus front porch
  localparam screenCoord_t hActiveEnd = screenCoord_t'(hActive);
  localparam screenCoord_t vActiveEnd = screenCoord_t'(vActive);
  localparam screenCoord_t hSyncStart = screenCoord_t'(hActive + hFront);
  localparam screenCoord_t vSyncStart = screenCoord_t'(vActive + vFront);
  localparam screenCoord_t hSyncEnd   = screenCoord_t'(hActive + hFront + hSync);
  localparam screenCoord_t vSyncEnd   = screenCoord_t'(vActive + vFront + vSync);

  logic lineEnd;
  logic frameEnd;

  assign lineEnd  = (hPos == hLast);
  assign frameEnd = (vPos == vLast);

  // pixel counter, wraps once per line
  always_ff @(posedge clk) begin
    if (rst) begin
      hPos <= '0;
    end else if (lineEnd) begin
      hPos <= '0;
    end else begin
      hPos <= hPos + 1'b1;
    end
  end

  // line counter, steps on each horizontal wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      vPos <= '0;
    end else if (lineEnd) begin
      if (frameEnd) begin
        vPos <= '0;
      end else begin
        vPos <= vPos + 1'b1;
      end
    end
  end

  // visible region
  assign active = (hPos < hActiveEnd) && (vPos < vActiveEnd);

  // syncs are active low inside their window
  assign hsyncRaw = !((hPos >= hSyncStart) && (hPos < hSyncEnd));
  assign vsyncRaw = !((vPos >= vSyncStart) && (vPos < vSyncEnd));

endmodule

// ==== source/brushControl.sv ====
`timescale 1ns/1ps

module brushControl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 brush,
  input  logic                 clearCanvas,
  input  colorPkg::colorCode_t newColor,
  input  vgaPkg::canvasCoord_t wx,
  input  vgaPkg::canvasCoord_t wy,
  output logic                 wrEn,
  output vgaPkg::canvasAddr_t  wrAddr,
  output colorPkg::colorCode_t wrColor,
  output logic                 clearBusy
);

  import vgaPkg::*;
  import colorPkg::*;

  typedef enum logic {
    idle,
    sweeping
  } brushState_t;

  localparam canvasCoord_t canvasEdge = canvasCoord_t'(CANVAS_SIZE);
  localparam canvasAddr_t  lastAddr   = canvasAddr_t'(CANVAS_DEPTH - 1);

  brushState_t state;

  // sweep position during a clear
  canvasAddr_t sweepAddr;

  // registered stroke
  logic        strokeEn;
  canvasAddr_t strokeAddr;
  colorCode_t  strokeColor;

  logic onCanvas;

  // both coordinates must land inside the canvas
  assign onCanvas = (wx < canvasEdge) && (wy < canvasEdge);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      sweepAddr <= '0;
      strokeEn  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          // clear takes priority over a stroke in the same cycle
          if (clearCanvas) begin
            state     <= sweeping;
            sweepAddr <= '0;
            strokeEn  <= 1'b0;
          end else begin
            strokeEn <= brush && onCanvas;
          end
        end
        sweeping: begin
          // strokes and repeated clears are dropped here
          strokeEn <= 1'b0;
          if (sweepAddr == lastAddr) begin
            state <= idle;
          end
          sweepAddr <= sweepAddr + 1'b1;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // stroke payload, only meaningful with strokeEn
  always_ff @(posedge clk) begin
    if (brush && onCanvas) begin
      strokeAddr  <= {wy[6:0], wx[6:0]};
      strokeColor <= newColor;
    end
  end

  assign clearBusy = (state == sweeping);

  // sweep owns the write port while busy
  assign wrEn    = clearBusy || strokeEn;
  assign wrAddr  = clearBusy ? sweepAddr : strokeAddr;
  assign wrColor = clearBusy ? erase : strokeColor;

endmodule

// ==== pixelStore/pixelStore.sv ====
`timescale 1ns/1ps

module pixelStore (
  input  logic                 clk,
  input  logic                 wrEn,
  input  vgaPkg::canvasAddr_t  wrAddr,
  input  colorPkg::colorCode_t wrColor,
  input  vgaPkg::screenCoord_t hPos,
  input  vgaPkg::screenCoord_t vPos,
  output colorPkg::colorCode_t colorCode
);

  import vgaPkg::*;
  import colorPkg::*;

  localparam screenCoord_t canvasEdge = screenCoord_t'(CANVAS_SIZE);

  // one color code per canvas pixel
  colorCode_t canvas [CANVAS_DEPTH];

  canvasAddr_t rdAddr;
  colorCode_t  ramData;
  logic        offCanvas;
  logic        offCanvasQ;

  // scan position folded onto the canvas
  assign rdAddr = {vPos[6:0], hPos[6:0]};

  // anything at or past the canvas edge
  assign offCanvas = (hPos >= canvasEdge) || (vPos >= canvasEdge);

  // single write port
  always_ff @(posedge clk) begin
    if (wrEn) begin
      canvas[wrAddr] <= wrColor;
    end
  end

  // registered read
  // same address as a write returns the old word
  always_ff @(posedge clk) begin
    ramData <= canvas[rdAddr];
  end

  // flag follows the read by the same cycle
  always_ff @(posedge clk) begin
    offCanvasQ <= offCanvas;
  end

  // outside code replaces the folded read
  assign colorCode = offCanvasQ ? outside : ramData;

endmodule

// ==== pixelStore/colorPalette.sv ====
`timescale 1ns/1ps

module colorPalette (
  input  logic                 clk,
  input  logic                 rst,
  input  colorPkg::colorCode_t colorCode,
  input  logic                 activeDly,
  output colorPkg::rgb_t       rgb
);

  import colorPkg::*;

  rgb_t lookup;

  // table lookup
  assign lookup = paletteTable[colorCode];

  // second pixel stage
  // black in reset and during blanking
  always_ff @(posedge clk) begin
    if (rst) begin
      rgb <= rgbBlack;
    end else if (!activeDly) begin
      rgb <= rgbBlack;
    end else begin
      rgb <= lookup;
    end
  end

endmodule

// ==== source/paintTop.sv ====
`timescale 1ns/1ps

module paintTop #(
  parameter int hActive = 640,
  parameter int hFront  = 16,
  parameter int hSync   = 96,
  parameter int hBack   = 48,
  parameter int vActive = 480,
  parameter int vFront  = 10,
  parameter int vSync   = 2,
  parameter int vBack   = 33
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 brush,
  input  logic                 clearCanvas,
  input  colorPkg::colorCode_t newColor,
  input  vgaPkg::canvasCoord_t wx,
  input  vgaPkg::canvasCoord_t wy,
  output logic                 hsync,
  output logic                 vsync,
  output colorPkg::rgb_t       rgb,
  output logic                 clearBusy
);

  import vgaPkg::*;
  import colorPkg::*;

  // scan side
  screenCoord_t hPos;
  screenCoord_t vPos;
  logic         active;
  logic         hsyncRaw;
  logic         vsyncRaw;

  // brush side
  logic         wrEn;
  canvasAddr_t  wrAddr;
  colorCode_t   wrColor;

  // pixel pipe
  colorCode_t   colorCode;
  logic         activeDly;

  // two-stage sync delay, msb feeds the pins
  logic [1:0]   hsyncDly;
  logic [1:0]   vsyncDly;

  vgaTiming #(
    .hActive (hActive),
    .hFront  (hFront),
    .hSync   (hSync),
    .hBack   (hBack),
    .vActive (vActive),
    .vFront  (vFront),
    .vSync   (vSync),
    .vBack   (vBack)
  ) uTiming (
    .clk      (clk),
    .rst      (rst),
    .hPos     (hPos),
    .vPos     (vPos),
    .active   (active),
    .hsyncRaw (hsyncRaw),
    .vsyncRaw (vsyncRaw)
  );

  brushControl uBrush (
    .clk         (clk),
    .rst         (rst),
    .brush       (brush),
    .clearCanvas (clearCanvas),
    .newColor    (newColor),
    .wx          (wx),
    .wy          (wy),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrColor     (wrColor),
    .clearBusy   (clearBusy)
  );

  pixelStore uStore (
    .clk       (clk),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrColor   (wrColor),
    .hPos      (hPos),
    .vPos      (vPos),
    .colorCode (colorCode)
  );

  colorPalette uPalette (
    .clk       (clk),
    .rst       (rst),
    .colorCode (colorCode),
    .activeDly (activeDly),
    .rgb       (rgb)
  );

  // active lines up with the RAM read stage
  always_ff @(posedge clk) begin
    if (rst) begin
      activeDly <= 1'b0;
    end else begin
      activeDly <= active;
    end
  end

  // syncs trail the counters by the RAM read plus the palette register
  // idle level is high
  always_ff @(posedge clk) begin
    if (rst) begin
      hsyncDly <= 2'b11;
      vsyncDly <= 2'b11;
    end else begin
      hsyncDly <= {hsyncDly[0], hsyncRaw};
      vsyncDly <= {vsyncDly[0], vsyncRaw};
    end
  end

  assign hsync = hsyncDly[1];
  assign vsync = vsyncDly[1];

endmodule

// ==== verif/paintTop_sva.sv ====
`timescale 1ns/1ps

module paintTop_sva #(
  parameter int hSync = 96
) (
  input logic           clk,
  input logic           rst,
  input logic           hsync,
  input logic           clearBusy,
  input logic           activeDly,
  input colorPkg::rgb_t rgb
);

  import vgaPkg::*;
  import colorPkg::*;

  // length of the running low or busy stretch
  int hsyncLow;
  int busyRun;

  always_ff @(posedge clk) begin
    if (rst || hsync) begin
      hsyncLow <= 0;
    end else begin
      hsyncLow <= hsyncLow + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !clearBusy) begin
      busyRun <= 0;
    end else begin
      busyRun <= busyRun + 1;
    end
  end

  hsyncWidth: assert property (@(posedge clk) disable iff (rst)
    $rose(hsync) |-> hsyncLow == hSync)
    else $error("hsync pulse lasted %0d cycles", hsyncLow);

  // one word per cycle over the whole canvas
  sweepLength: assert property (@(posedge clk) disable iff (rst)
    $fell(clearBusy) |-> busyRun == CANVAS_DEPTH)
    else $error("clearBusy lasted %0d cycles", busyRun);

  blankBlack: assert property (@(posedge clk) disable iff (rst)
    !activeDly |=> rgb == rgbBlack)
    else $error("rgb not black in blanking");

endmodule

bind paintTop paintTop_sva #(.hSync(hSync)) uSva (
  .clk       (clk),
  .rst       (rst),
  .hsync     (hsync),
  .clearBusy (clearBusy),
  .activeDly (activeDly),
  .rgb       (rgb)
);

// ==== verif/paintTb.sv ====
`timescale 1ns/1ps

module paintTb;

  import vgaPkg::*;
  import colorPkg::*;

  // short frames keep the run fast
  localparam int hActive = 160;
  localparam int hFront  = 4;
  localparam int hSync   = 8;
  localparam int hBack   = 4;
  localparam int vActive = 136;
  localparam int vFront  = 2;
  localparam int vSync   = 2;
  localparam int vBack   = 2;
  localparam int hTotal  = hActive + hFront + hSync + hBack;
  localparam int vTotal  = vActive + vFront + vSync + vBack;
  localparam int frameCycles = hTotal * vTotal;
  // one full sweep plus a stretch of accepted strokes
  localparam int randomCycles = CANVAS_DEPTH + 2000;

  // vector opcode sits in the top hex digit of each word
  localparam logic [3:0] opPaint = 4'h1;
  localparam logic [3:0] opClear = 4'h2;
  localparam logic [3:0] opCheck = 4'h3;
  localparam logic [3:0] opEnd   = 4'hF;

  logic         clk = 1'b0;
  logic         rst;
  logic         brush;
  logic         clearCanvas;
  colorCode_t   newColor;
  canvasCoord_t wx;
  canvasCoord_t wy;
  logic         hsync;
  logic         vsync;
  rgb_t         rgb;
  logic         clearBusy;

  logic [23:0]  vectors [64];
  int           numVectors;
  int           cycleCount = 0;
  int           cycleLimit;
  integer       seed;
  int           busyLeft = 0;
  logic         frameCheck = 1'b0;
  string        currentTest = "reset";
  colorCode_t   canvasModel [CANVAS_SIZE][CANVAS_SIZE];

  // scan model
  // d2 holds the position now showing at rgb
  int scanH = 0;
  int scanV = 0;
  int d1H = 0;
  int d1V = 0;
  int d2H = 0;
  int d2V = 0;
  bit d1Valid = 1'b0;
  bit d2Valid = 1'b0;

  paintTop #(
    .hActive (hActive),
    .hFront  (hFront),
    .hSync   (hSync),
    .hBack   (hBack),
    .vActive (vActive),
    .vFront  (vFront),
    .vSync   (vSync),
    .vBack   (vBack)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .brush       (brush),
    .clearCanvas (clearCanvas),
    .newColor    (newColor),
    .wx          (wx),
    .wy          (wy),
    .hsync       (hsync),
    .vsync       (vsync),
    .rgb         (rgb),
    .clearBusy   (clearBusy)
  );

  always #2 clk = ~clk;

  // counters start at zero in the first cycle after reset
  always @(posedge clk) begin
    if (rst) begin
      scanH   <= 0;
      scanV   <= 0;
      d1Valid <= 1'b0;
      d2Valid <= 1'b0;
    end else begin
      if (scanH == hTotal - 1) begin
        scanH <= 0;
        scanV <= (scanV == vTotal - 1) ? 0 : scanV + 1;
      end else begin
        scanH <= scanH + 1;
      end
      d1H     <= scanH;
      d1V     <= scanV;
      d1Valid <= 1'b1;
      d2H     <= d1H;
      d2V     <= d1V;
      d2Valid <= d1Valid;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("timeout after %0d cycles, the run did not complete", cycleCount);
      $display("TESTBENCH FAILED");
      $fatal(1, "run limit reached");
    end
  end

  task automatic checkRgb(input string what, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", currentTest, what, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "rgb compare");
    end
  endtask

  task automatic checkSync(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %b actual %b", currentTest, what, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "sync compare");
    end
  endtask

  task automatic checkBusy(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %b actual %b", currentTest, what, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "busy compare");
    end
  endtask

  function automatic colorCode_t expectedCode(input int x, input int y);
    if (x >= CANVAS_SIZE || y >= CANVAS_SIZE) begin
      return outside;
    end
    return canvasModel[y][x];
  endfunction

  // advance one clock and judge every output
  task automatic stepCycle();
    logic expActive;
    logic expH;
    logic expV;
    @(posedge clk);
    #0.5;
    expActive = d2Valid && (d2H < hActive) && (d2V < vActive);
    expH = !(d2Valid && d2H >= hActive + hFront && d2H < hActive + hFront + hSync);
    expV = !(d2Valid && d2V >= vActive + vFront && d2V < vActive + vFront + vSync);
    checkBusy("clearBusy", busyLeft > 0, clearBusy);
    checkSync("hsync", expH, hsync);
    checkSync("vsync", expV, vsync);
    if (!expActive) begin
      checkRgb("rgb in blanking", rgbBlack, rgb);
    end else if (frameCheck) begin
      checkRgb($sformatf("rgb at %0d,%0d", d2H, d2V),
               paletteTable[expectedCode(d2H, d2V)], rgb);
    end
  endtask

  // drive one cycle of stimulus and apply it to the model
  task automatic applyCycle(input logic doBrush, input logic doClear,
                            input colorCode_t color, input canvasCoord_t x,
                            input canvasCoord_t y);
    int row;
    int col;
    brush       = doBrush;
    clearCanvas = doClear;
    newColor    = color;
    wx          = x;
    wy          = y;
    // nothing else is taken while busy counts down
    if (busyLeft > 0) begin
      busyLeft--;
    end else if (doClear) begin
      busyLeft = CANVAS_DEPTH;
      for (row = 0; row < CANVAS_SIZE; row++) begin
        for (col = 0; col < CANVAS_SIZE; col++) begin
          canvasModel[row][col] = erase;
        end
      end
    end else if (doBrush && int'(x) < CANVAS_SIZE && int'(y) < CANVAS_SIZE) begin
      canvasModel[int'(y)][int'(x)] = color;
    end
    stepCycle();
  endtask

  task automatic idleCycle();
    applyCycle(1'b0, 1'b0, erase, '0, '0);
  endtask

  task automatic checkFrame();
    // wait out a running sweep, then let the last stroke land
    while (clearBusy) begin
      idleCycle();
    end
    repeat (4) idleCycle();
    // frame origin at rgb
    while (!(d2Valid && d2H == 0 && d2V == 0)) begin
      idleCycle();
    end
    frameCheck = 1'b1;
    repeat (frameCycles) idleCycle();
    frameCheck = 1'b0;
  endtask

  task automatic runVectors();
    int i;
    logic [23:0] word;
    for (i = 0; i < numVectors; i++) begin
      word = vectors[i];
      currentTest = $sformatf("vector %0d", i);
      case (word[23:20])
        opPaint: applyCycle(1'b1, 1'b0, word[18:16], word[15:8], word[7:0]);
        opClear: applyCycle(1'b0, 1'b1, erase, '0, '0);
        opCheck: checkFrame();
        default: begin
          $display("vector %0d holds an unknown opcode %h", i, word[23:20]);
          $display("TESTBENCH FAILED");
          $fatal(1, "bad vector");
        end
      endcase
    end
  endtask

  // strokes aimed at words the sweep has already erased
  // a stroke taken here would stay visible after the sweep
  task automatic strokesDuringSweep();
    currentTest = "strokes during sweep";
    applyCycle(1'b0, 1'b1, erase, '0, '0);
    applyCycle(1'b1, 1'b0, white, 8'd0, 8'd0);
    applyCycle(1'b0, 1'b1, erase, '0, '0);
    applyCycle(1'b1, 1'b0, purple, 8'd1, 8'd0);
    checkFrame();
  endtask

  task automatic randomRun();
    logic [31:0]  r;
    canvasCoord_t x;
    canvasCoord_t y;
    currentTest = "random strokes";
    applyCycle(1'b0, 1'b1, erase, '0, '0);
    repeat (randomCycles) begin
      r = $random(seed);
      x = r[7:0];
      y = r[15:8];
      // three in four strokes pulled onto the canvas
      if (r[17:16] != 2'b00) begin
        x[7] = 1'b0;
        y[7] = 1'b0;
      end
      if (busyLeft > 0 && r[23:19] == 5'd0) begin
        applyCycle(1'b0, 1'b1, erase, x, y);
      end else begin
        applyCycle(r[18], 1'b0, r[26:24], x, y);
      end
    end
    checkFrame();
  endtask

  initial begin
    rst         = 1'b1;
    brush       = 1'b0;
    clearCanvas = 1'b0;
    newColor    = erase;
    wx          = '0;
    wy          = '0;
    seed        = 74;
    $readmemh("verif/paintVectors.mem", vectors);
    numVectors = 0;
    while (numVectors < 64 && vectors[numVectors][23:20] !== opEnd) begin
      numVectors++;
    end
    cycleLimit = (numVectors + 2) * (frameCycles + CANVAS_DEPTH)
               + randomCycles + 2 * frameCycles;
    repeat (10) @(posedge clk);
    #0.5;
    rst = 1'b0;
    runVectors();
    strokesDuringSweep();
    randomRun();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== verif/paintVectors.mem ====
// one word per command, hex digits O C XX YY
// O opcode (1 paint, 2 clear, 3 frame check, F end), C color, XX wx, YY wy
200000
300000
110507
120A03
137F00
14007F
157F7F
160000
174020
113C3C
128000
131080
14FFFF
15807F
300000
200000
161010
172020
200000
133030
300000
115A5A
126464
300000
F00000

// ==== verilog.f ====
common/vgaPkg.sv
common/colorPkg.sv
source/vgaTiming.sv
source/brushControl.sv
pixelStore/pixelStore.sv
pixelStore/colorPalette.sv
source/paintTop.sv
verif/paintTop_sva.sv
verif/paintTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module paintTb -f verilog.f -o paintSim &&
  ./obj_dir/paintSim ||
  { echo "paint simulation failed"; exit 1; }
